//--- source/vlane_pkg.sv
`default_nettype none

package vlane_pkg;

   ////////////////////
   // Storage sizes
   ////////////////////
   localparam int vrf_depth      = 64;
   localparam int vrf_addr_w     = 6;
   localparam int mask_depth     = 32;
   localparam int mask_addr_w    = 5;
   localparam int word_w         = 32;
   localparam int bytes_per_word = 4;
   localparam int imm_w          = 5;

   // Register stages from issue to ALU result
   localparam int stage_n = 3;

   ////////////////////
   // Encodings
   ////////////////////
   // Code 3 is reserved
   typedef enum logic [1:0] {sew_8, sew_16, sew_32} sew_t;

   typedef logic [1:0] el_idx_t;

   typedef enum logic [2:0] {
      op_add, op_sub, op_and, op_or, op_xor, op_mseq, op_msltu
   } alu_op_t;

   // Code 3 selects zero
   typedef enum logic [1:0] {op2_vector, op2_scalar, op2_imm} op2_sel_t;

   // One VRF word, seen per element width
   typedef union packed {
      logic [word_w-1:0]                word;
      logic [1:0][15:0]                 half;
      logic [bytes_per_word-1:0][7:0]   bytes;
   } vlane_word_u;

endpackage

`default_nettype wire

//--- source/vlane_vrf.sv
`default_nettype none

module vlane_vrf
   import vlane_pkg::*;
(
   input  logic                      clk_i,
   input  logic [vrf_addr_w-1:0]     raddr_a_i,
   input  logic [vrf_addr_w-1:0]     raddr_b_i,
   output logic [word_w-1:0]         rdata_a_o,
   output logic [word_w-1:0]         rdata_b_o,
   input  logic [vrf_addr_w-1:0]     waddr_i,
   input  logic [word_w-1:0]         wdata_i,
   input  logic [bytes_per_word-1:0] wbe_i
);

   logic [word_w-1:0] mem [vrf_depth];

   // Registered reads, old data on a collision
   always_ff @(posedge clk_i) begin
      rdata_a_o <= mem[raddr_a_i];
      rdata_b_o <= mem[raddr_b_i];
   end

   // Byte-enabled write port
   always_ff @(posedge clk_i) begin
      for (int b = 0; b < bytes_per_word; b++) begin
         if (wbe_i[b]) begin
            mem[waddr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
         end
      end
   end

endmodule

`default_nettype wire

//--- source/vlane_mask_file.sv
`default_nettype none

module vlane_mask_file
   import vlane_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic [mask_addr_w-1:0] raddr_i,
   output logic                   rbit_o,
   input  logic [mask_addr_w-1:0] waddr_i,
   input  logic                   wen_i,
   input  logic                   wbit_i
);

   logic [mask_depth-1:0] bits_q;

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         bits_q <= '0;
      end else if (wen_i) begin
         bits_q[waddr_i] <= wbit_i;
      end
   end

   // Asynchronous read for writeback gating
   assign rbit_o = bits_q[raddr_i];

endmodule

`default_nettype wire

//--- source/vlane_issue_pipe.sv
`default_nettype none

module vlane_issue_pipe
   import vlane_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   issue_valid_i,
   input  sew_t                   vsew_i,
   input  el_idx_t                el_idx_i,
   input  op2_sel_t               op2_sel_i,
   input  logic [word_w-1:0]      scalar_i,
   input  logic [imm_w-1:0]       imm_i,
   input  alu_op_t                alu_op_i,
   input  logic [vrf_addr_w-1:0]  vd_addr_i,
   input  logic                   wb_en_i,
   input  logic                   wb_load_i,
   input  logic [word_w-1:0]      load_data_i,
   input  logic                   masked_i,
   input  logic [mask_addr_w-1:0] mask_addr_i,
   input  logic                   mask_wen_i,
   // Extraction stage
   output sew_t                   s1_sew_o,
   output el_idx_t                s1_el_idx_o,
   // ALU stage
   output logic                   s2_valid_o,
   output alu_op_t                s2_alu_op_o,
   output op2_sel_t               s2_op2_sel_o,
   output logic [word_w-1:0]      s2_scalar_o,
   output logic [imm_w-1:0]       s2_imm_o,
   // Writeback stage
   output logic                   s3_valid_o,
   output sew_t                   s3_sew_o,
   output el_idx_t                s3_el_idx_o,
   output logic [vrf_addr_w-1:0]  s3_vd_addr_o,
   output logic                   s3_wb_en_o,
   output logic                   s3_wb_load_o,
   output logic [word_w-1:0]      s3_load_data_o,
   output logic                   s3_masked_o,
   output logic [mask_addr_w-1:0] s3_mask_addr_o,
   output logic                   s3_mask_wen_o
);

   logic [stage_n-1:0] valid_q;

   // Stage 1 holds everything that is still needed later
   alu_op_t                s1_alu_op;
   op2_sel_t               s1_op2_sel;
   logic [word_w-1:0]      s1_scalar;
   logic [imm_w-1:0]       s1_imm;
   logic [vrf_addr_w-1:0]  s1_vd_addr, s2_vd_addr;
   logic                   s1_wb_en, s2_wb_en;
   logic                   s1_wb_load, s2_wb_load;
   logic [word_w-1:0]      s1_load_data, s2_load_data;
   logic                   s1_masked, s2_masked;
   logic [mask_addr_w-1:0] s1_mask_addr, s2_mask_addr;
   logic                   s1_mask_wen, s2_mask_wen;
   sew_t                   s2_sew;
   el_idx_t                s2_el_idx;

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         valid_q <= '0;
      end else begin
         valid_q <= {valid_q[stage_n-2:0], issue_valid_i};
      end
   end

   ////////////////////
   // Control fields
   ////////////////////
   always_ff @(posedge clk_i) begin
      s1_sew_o     <= vsew_i;
      s1_el_idx_o  <= el_idx_i;
      s1_alu_op    <= alu_op_i;
      s1_op2_sel   <= op2_sel_i;
      s1_scalar    <= scalar_i;
      s1_imm       <= imm_i;
      s1_vd_addr   <= vd_addr_i;
      s1_wb_en     <= wb_en_i;
      s1_wb_load   <= wb_load_i;
      s1_load_data <= load_data_i;
      s1_masked    <= masked_i;
      s1_mask_addr <= mask_addr_i;
      s1_mask_wen  <= mask_wen_i;

      // ALU fields leave here
      s2_alu_op_o  <= s1_alu_op;
      s2_op2_sel_o <= s1_op2_sel;
      s2_scalar_o  <= s1_scalar;
      s2_imm_o     <= s1_imm;
      s2_sew       <= s1_sew_o;
      s2_el_idx    <= s1_el_idx_o;
      s2_vd_addr   <= s1_vd_addr;
      s2_wb_en     <= s1_wb_en;
      s2_wb_load   <= s1_wb_load;
      s2_load_data <= s1_load_data;
      s2_masked    <= s1_masked;
      s2_mask_addr <= s1_mask_addr;
      s2_mask_wen  <= s1_mask_wen;

      s3_sew_o       <= s2_sew;
      s3_el_idx_o    <= s2_el_idx;
      s3_vd_addr_o   <= s2_vd_addr;
      s3_wb_en_o     <= s2_wb_en;
      s3_wb_load_o   <= s2_wb_load;
      s3_load_data_o <= s2_load_data;
      s3_masked_o    <= s2_masked;
      s3_mask_addr_o <= s2_mask_addr;
      s3_mask_wen_o  <= s2_mask_wen;
   end

   assign s2_valid_o = valid_q[1];
   assign s3_valid_o = valid_q[2];

endmodule

`default_nettype wire

//--- source/vlane_operand_extract.sv
`default_nettype none

module vlane_operand_extract
   import vlane_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic [word_w-1:0] word_i,
   input  sew_t              sew_i,
   input  el_idx_t           el_idx_i,
   output logic [word_w-1:0] elem_o
);

   vlane_word_u       src;
   logic [word_w-1:0] elem_d;

   // Pick the element and zero-extend it
   always_comb begin
      src.word = word_i;
      case (sew_i)
         sew_8:   elem_d = {{(word_w-8){1'b0}}, src.bytes[el_idx_i]};
         sew_16:  elem_d = {{(word_w-16){1'b0}}, src.half[el_idx_i[0]]};
         sew_32:  elem_d = src.word;
         // reserved width reads as zero
         default: elem_d = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         elem_o <= '0;
      end else begin
         elem_o <= elem_d;
      end
   end

endmodule

`default_nettype wire

//--- source/vlane_alu.sv
`default_nettype none

module vlane_alu
   import vlane_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              valid_i,
   input  alu_op_t           alu_op_i,
   input  op2_sel_t          op2_sel_i,
   input  logic [word_w-1:0] op1_i,
   input  logic [word_w-1:0] vec2_i,
   input  logic [word_w-1:0] scalar_i,
   input  logic [imm_w-1:0]  imm_i,
   output logic [word_w-1:0] result_o,
   output logic              cmp_o,
   output logic              valid_o
);

   logic [word_w-1:0] op2;
   logic [word_w-1:0] result_d;

   ////////////////////
   // Second operand
   ////////////////////
   always_comb begin
      case (op2_sel_i)
         op2_vector: op2 = vec2_i;
         op2_scalar: op2 = scalar_i;
         op2_imm:    op2 = {{(word_w-imm_w){1'b0}}, imm_i};
         default:    op2 = '0;
      endcase
   end

   ////////////////////
   // Operation
   ////////////////////
   always_comb begin
      case (alu_op_i)
         op_add:   result_d = op1_i + op2;
         op_sub:   result_d = op1_i - op2;
         op_and:   result_d = op1_i & op2;
         op_or:    result_d = op1_i | op2;
         op_xor:   result_d = op1_i ^ op2;
         // Compares give 1 or 0
         op_mseq:  result_d = {{(word_w-1){1'b0}}, op1_i == op2};
         op_msltu: result_d = {{(word_w-1){1'b0}}, op1_i < op2};
         default:  result_d = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         valid_o <= 1'b0;
      end else begin
         valid_o <= valid_i;
      end
   end

   always_ff @(posedge clk_i) begin
      result_o <= result_d;
   end

   // Mask bit for compares
   assign cmp_o = result_o[0];

endmodule

`default_nettype wire

//--- source/vlane_writeback.sv
`default_nettype none

module vlane_writeback
   import vlane_pkg::*;
(
   input  logic                      valid_i,
   input  sew_t                      sew_i,
   input  el_idx_t                   el_idx_i,
   input  logic [vrf_addr_w-1:0]     vd_addr_i,
   input  logic                      wb_en_i,
   input  logic                      wb_load_i,
   input  logic [word_w-1:0]         load_data_i,
   input  logic [word_w-1:0]         alu_result_i,
   input  logic                      cmp_i,
   input  logic                      masked_i,
   input  logic [mask_addr_w-1:0]    mask_addr_i,
   input  logic                      mask_wen_i,
   input  logic                      mask_bit_i,
   output logic [vrf_addr_w-1:0]     vrf_waddr_o,
   output logic [word_w-1:0]         vrf_wdata_o,
   output logic [bytes_per_word-1:0] vrf_wbe_o,
   output logic [mask_addr_w-1:0]    mask_raddr_o,
   output logic [mask_addr_w-1:0]    mask_waddr_o,
   output logic                      mask_wen_o,
   output logic                      mask_wbit_o
);

   logic [word_w-1:0]         src;
   vlane_word_u               repl;
   logic [bytes_per_word-1:0] be;
   logic                      write_ok;

   ////////////////////
   // Data and enables
   ////////////////////
   always_comb begin
      src = wb_load_i ? load_data_i : alu_result_i;
      case (sew_i)
         sew_8: begin
            repl.bytes = {bytes_per_word{src[7:0]}};
            be         = 4'b0001 << el_idx_i;
         end
         sew_16: begin
            repl.half = {2{src[15:0]}};
            be        = el_idx_i[0] ? 4'b1100 : 4'b0011;
         end
         sew_32: begin
            repl.word = src;
            be        = '1;
         end
         default: begin
            repl.word = '0;
            be        = '0;
         end
      endcase
   end

   // Masked writes need their mask bit set
   assign write_ok = valid_i & wb_en_i & (~masked_i | mask_bit_i);

   assign vrf_waddr_o = vd_addr_i;
   assign vrf_wdata_o = repl.word;
   assign vrf_wbe_o   = be & {bytes_per_word{write_ok}};

   // Compare results go to the mask file unmasked
   assign mask_raddr_o = mask_addr_i;
   assign mask_waddr_o = mask_addr_i;
   assign mask_wen_o   = valid_i & mask_wen_i;
   assign mask_wbit_o  = cmp_i;

endmodule

`default_nettype wire

//--- source/vector_lane.sv
`default_nettype none

module vector_lane
   import vlane_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   rst_i,
   // Issue port
   input  logic                   issue_valid_i,
   input  sew_t                   vsew_i,
   input  el_idx_t                el_idx_i,
   input  logic [vrf_addr_w-1:0]  vs1_addr_i,
   input  logic [vrf_addr_w-1:0]  vs2_addr_i,
   input  op2_sel_t               op2_sel_i,
   input  logic [word_w-1:0]      scalar_i,
   input  logic [imm_w-1:0]       imm_i,
   input  alu_op_t                alu_op_i,
   input  logic [vrf_addr_w-1:0]  vd_addr_i,
   input  logic                   wb_en_i,
   input  logic                   wb_load_i,
   input  logic [word_w-1:0]      load_data_i,
   input  logic                   masked_i,
   input  logic [mask_addr_w-1:0] mask_addr_i,
   input  logic                   mask_wen_i,
   // Result
   output logic [word_w-1:0]      result_o,
   output logic                   result_valid_o
);

   ////////////////////
   // Stage control
   ////////////////////
   sew_t                   s1_sew, s3_sew;
   el_idx_t                s1_el_idx, s3_el_idx;
   logic                   s2_valid, s3_valid;
   alu_op_t                s2_alu_op;
   op2_sel_t               s2_op2_sel;
   logic [word_w-1:0]      s2_scalar;
   logic [imm_w-1:0]       s2_imm;
   logic [vrf_addr_w-1:0]  s3_vd_addr;
   logic                   s3_wb_en, s3_wb_load, s3_masked, s3_mask_wen;
   logic [word_w-1:0]      s3_load_data;
   logic [mask_addr_w-1:0] s3_mask_addr;

   ////////////////////
   // Datapath
   ////////////////////
   logic [word_w-1:0]         rdata_a, rdata_b;
   logic [word_w-1:0]         elem_a, elem_b;
   logic                      alu_cmp;
   logic [vrf_addr_w-1:0]     vrf_waddr;
   logic [word_w-1:0]         vrf_wdata;
   logic [bytes_per_word-1:0] vrf_wbe;
   logic [mask_addr_w-1:0]    mask_raddr, mask_waddr;
   logic                      mask_rbit, mask_wen, mask_wbit;

   vlane_issue_pipe u_issue_pipe (
      .clk_i, .rst_i, .issue_valid_i, .vsew_i, .el_idx_i,
      .op2_sel_i, .scalar_i, .imm_i, .alu_op_i,
      .vd_addr_i, .wb_en_i, .wb_load_i, .load_data_i,
      .masked_i, .mask_addr_i, .mask_wen_i,
      .s1_sew_o       (s1_sew),
      .s1_el_idx_o    (s1_el_idx),
      .s2_valid_o     (s2_valid),
      .s2_alu_op_o    (s2_alu_op),
      .s2_op2_sel_o   (s2_op2_sel),
      .s2_scalar_o    (s2_scalar),
      .s2_imm_o       (s2_imm),
      .s3_valid_o     (s3_valid),
      .s3_sew_o       (s3_sew),
      .s3_el_idx_o    (s3_el_idx),
      .s3_vd_addr_o   (s3_vd_addr),
      .s3_wb_en_o     (s3_wb_en),
      .s3_wb_load_o   (s3_wb_load),
      .s3_load_data_o (s3_load_data),
      .s3_masked_o    (s3_masked),
      .s3_mask_addr_o (s3_mask_addr),
      .s3_mask_wen_o  (s3_mask_wen)
   );

   vlane_vrf u_vrf (
      .clk_i,
      .raddr_a_i (vs1_addr_i),
      .raddr_b_i (vs2_addr_i),
      .rdata_a_o (rdata_a),
      .rdata_b_o (rdata_b),
      .waddr_i   (vrf_waddr),
      .wdata_i   (vrf_wdata),
      .wbe_i     (vrf_wbe)
   );

   vlane_mask_file u_mask_file (
      .clk_i, .rst_i,
      .raddr_i (mask_raddr),
      .rbit_o  (mask_rbit),
      .waddr_i (mask_waddr),
      .wen_i   (mask_wen),
      .wbit_i  (mask_wbit)
   );

   // One extractor per operand
   vlane_operand_extract u_extract_a (
      .clk_i, .rst_i,
      .word_i   (rdata_a),
      .sew_i    (s1_sew),
      .el_idx_i (s1_el_idx),
      .elem_o   (elem_a)
   );

   vlane_operand_extract u_extract_b (
      .clk_i, .rst_i,
      .word_i   (rdata_b),
      .sew_i    (s1_sew),
      .el_idx_i (s1_el_idx),
      .elem_o   (elem_b)
   );

   vlane_alu u_alu (
      .clk_i, .rst_i,
      .valid_i   (s2_valid),
      .alu_op_i  (s2_alu_op),
      .op2_sel_i (s2_op2_sel),
      .op1_i     (elem_a),
      .vec2_i    (elem_b),
      .scalar_i  (s2_scalar),
      .imm_i     (s2_imm),
      .result_o  (result_o),
      .cmp_o     (alu_cmp),
      .valid_o   (result_valid_o)
   );

   vlane_writeback u_writeback (
      .valid_i      (s3_valid),
      .sew_i        (s3_sew),
      .el_idx_i     (s3_el_idx),
      .vd_addr_i    (s3_vd_addr),
      .wb_en_i      (s3_wb_en),
      .wb_load_i    (s3_wb_load),
      .load_data_i  (s3_load_data),
      .alu_result_i (result_o),
      .cmp_i        (alu_cmp),
      .masked_i     (s3_masked),
      .mask_addr_i  (s3_mask_addr),
      .mask_wen_i   (s3_mask_wen),
      .mask_bit_i   (mask_rbit),
      .vrf_waddr_o  (vrf_waddr),
      .vrf_wdata_o  (vrf_wdata),
      .vrf_wbe_o    (vrf_wbe),
      .mask_raddr_o (mask_raddr),
      .mask_waddr_o (mask_waddr),
      .mask_wen_o   (mask_wen),
      .mask_wbit_o  (mask_wbit)
   );

endmodule

`default_nettype wire

//--- testbench/tb_vector_lane_seq.svh
`ifndef TB_VECTOR_LANE_SEQ_SVH
`define TB_VECTOR_LANE_SEQ_SVH

////////////////////
// Issue drivers
////////////////////
task automatic clear_inputs();
   issue_valid_i <= 1'b0;
   vsew_i        <= sew_32;
   el_idx_i      <= '0;
   vs1_addr_i    <= '0;
   vs2_addr_i    <= '0;
   op2_sel_i     <= op2_zero;
   scalar_i      <= '0;
   imm_i         <= '0;
   alu_op_i      <= op_add;
   vd_addr_i     <= '0;
   wb_en_i       <= 1'b0;
   wb_load_i     <= 1'b0;
   load_data_i   <= '0;
   masked_i      <= 1'b0;
   mask_addr_i   <= '0;
   mask_wen_i    <= 1'b0;
endtask

task automatic drive_issue(
   input sew_t                   sew,
   input el_idx_t                idx,
   input logic [vrf_addr_w-1:0]  vs1,
   input logic [vrf_addr_w-1:0]  vs2,
   input op2_sel_t               sel,
   input logic [word_w-1:0]      scalar,
   input logic [imm_w-1:0]       imm,
   input alu_op_t                op,
   input logic [vrf_addr_w-1:0]  vd,
   input logic                   wb_en,
   input logic                   wb_load,
   input logic [word_w-1:0]      ldata,
   input logic                   masked,
   input logic [mask_addr_w-1:0] maddr,
   input logic                   mwen
);
   @(posedge clk_i);
   issue_valid_i <= 1'b1;
   vsew_i        <= sew;
   el_idx_i      <= idx;
   vs1_addr_i    <= vs1;
   vs2_addr_i    <= vs2;
   op2_sel_i     <= sel;
   scalar_i      <= scalar;
   imm_i         <= imm;
   alu_op_i      <= op;
   vd_addr_i     <= vd;
   wb_en_i       <= wb_en;
   wb_load_i     <= wb_load;
   load_data_i   <= ldata;
   masked_i      <= masked;
   mask_addr_i   <= maddr;
   mask_wen_i    <= mwen;
endtask

task automatic idle_cycles(input int n);
   repeat (n) begin
      @(posedge clk_i);
      issue_valid_i <= 1'b0;
   end
endtask

// ALU result is forced to zero so unwritten words do not matter
task automatic load_elem(input sew_t sew, input el_idx_t idx,
                         input logic [vrf_addr_w-1:0] vd, input logic [word_w-1:0] data,
                         input logic masked, input logic [mask_addr_w-1:0] maddr);
   drive_issue(sew, idx, '0, '0, op2_zero, '0, '0, op_and, vd, 1'b1, 1'b1, data,
               masked, maddr, 1'b0);
endtask

task automatic read_elem(input sew_t sew, input el_idx_t idx,
                         input logic [vrf_addr_w-1:0] vs);
   drive_issue(sew, idx, vs, vs, op2_imm, '0, '0, op_add, '0, 1'b0, 1'b0, '0,
               1'b0, '0, 1'b0);
endtask

////////////////////
// Test phases
////////////////////
task automatic init_words();
   for (int w = 0; w < vrf_depth; w++) begin
      load_elem(sew_32, 2'd0, w[vrf_addr_w-1:0], next_rand(), 1'b0, '0);
   end
   idle_cycles(4);
endtask

// Every SEW code, operation and second operand source
task automatic alu_sweep();
   logic [word_w-1:0] r1;
   logic [word_w-1:0] r2;
   for (int s = 0; s < 4; s++) begin
      for (int o = 0; o < 7; o++) begin
         for (int q = 0; q < 4; q++) begin
            r1 = next_rand();
            r2 = next_rand();
            drive_issue(sew_t'(s[1:0]), r1[1:0], r1[7:2], r1[13:8], op2_sel_t'(q[1:0]),
                        r2, r1[18:14], alu_op_t'(o[2:0]), '0, 1'b0, 1'b0, '0,
                        1'b0, '0, 1'b0);
         end
      end
      idle_cycles(2);
   end
endtask

// Words 16 to 31 each get one element and are read back bytewise
task automatic element_writes();
   int addr;
   for (int s = 0; s < 4; s++) begin
      for (int i = 0; i < 4; i++) begin
         addr = 16 + s * 4 + i;
         load_elem(sew_t'(s[1:0]), i[1:0], addr[vrf_addr_w-1:0], next_rand(), 1'b0, '0);
      end
   end
   idle_cycles(4);
   for (int w = 16; w < 32; w++) begin
      for (int i = 0; i < 4; i++) begin
         read_elem(sew_8, i[1:0], w[vrf_addr_w-1:0]);
      end
   end
   idle_cycles(4);
endtask

// Reads 1 to 4 cycles after a load
task automatic hazard_reads();
   load_elem(sew_32, 2'd0, 6'd40, next_rand(), 1'b0, '0);
   repeat (4) read_elem(sew_32, 2'd0, 6'd40);
   idle_cycles(4);
endtask

task automatic mask_writes();
   logic [word_w-1:0] r1;
   logic [word_w-1:0] r2;
   int                vd;
   // Even bits compare a word with itself
   for (int m = 0; m < 16; m++) begin
      r1 = next_rand();
      r2 = next_rand();
      if (!m[0]) begin
         drive_issue(sew_32, 2'd0, r1[5:0], r1[5:0], op2_vector, '0, '0, op_mseq, '0,
                     1'b0, 1'b0, '0, 1'b0, m[4:0], 1'b1);
      end else begin
         drive_issue(sew_32, 2'd0, r1[5:0], '0, op2_scalar, r2, '0, op_msltu, '0,
                     1'b0, 1'b0, '0, 1'b0, m[4:0], 1'b1);
      end
   end
   // Bits 16 to 19 are still clear from reset
   for (int m = 0; m < 20; m++) begin
      r1 = next_rand();
      r2 = next_rand();
      vd = 32 + m;
      if (!m[0]) begin
         load_elem(sew_32, 2'd0, vd[vrf_addr_w-1:0], r1, 1'b1, m[4:0]);
      end else begin
         drive_issue(sew_32, 2'd0, r1[5:0], '0, op2_scalar, r2, '0, op_add,
                     vd[vrf_addr_w-1:0], 1'b1, 1'b0, '0, 1'b1, m[4:0], 1'b0);
      end
   end
   // Unmasked writes that point at clear bits
   for (int m = 0; m < 12; m++) begin
      vd = 52 + m;
      r1 = 16 + m;
      load_elem(sew_32, 2'd0, vd[vrf_addr_w-1:0], next_rand(), 1'b0, r1[4:0]);
   end
   idle_cycles(4);
   for (int w = 32; w < 64; w++) begin
      read_elem(sew_32, 2'd0, w[vrf_addr_w-1:0]);
   end
   idle_cycles(4);
endtask

task automatic run_tests();
   idle_cycles(3);
   init_words();
   alu_sweep();
   element_writes();
   hazard_reads();
   mask_writes();
endtask

`endif

//--- testbench/tb_vector_lane.sv
`default_nettype none

module tb_vector_lane
   import vlane_pkg::*;
();

   localparam int reset_cycles = 10;

   // Issue and gap cycles of each test phase
   localparam int init_len   = 64 + 4;
   localparam int alu_len    = 4 * 7 * 4 + 4 * 2;
   localparam int elem_len   = 16 + 4 + 64 + 4;
   localparam int hazard_len = 1 + 4 + 4;
   localparam int mask_len   = 16 + 20 + 12 + 4 + 32 + 4;
   localparam int cycle_limit =
      2 * (reset_cycles + init_len + alu_len + elem_len + hazard_len + mask_len);

   localparam logic [1:0] kind_alu  = 2'd0;
   localparam logic [1:0] kind_read = 2'd1;
   localparam logic [1:0] kind_cmp  = 2'd2;
   localparam op2_sel_t   op2_zero  = op2_sel_t'(2'd3);

   typedef struct packed {
      logic                   valid;
      logic [1:0]             kind;
      logic [word_w-1:0]      result;
      logic                   wb_en;
      logic [vrf_addr_w-1:0]  vd;
      logic [word_w-1:0]      wdata;
      sew_t                   sew;
      el_idx_t                idx;
      logic                   masked;
      logic [mask_addr_w-1:0] mask_addr;
      logic                   mask_wen;
   } exp_entry_t;

   logic                   clk_i;
   logic                   rst_i;
   logic                   issue_valid_i;
   sew_t                   vsew_i;
   el_idx_t                el_idx_i;
   logic [vrf_addr_w-1:0]  vs1_addr_i;
   logic [vrf_addr_w-1:0]  vs2_addr_i;
   op2_sel_t               op2_sel_i;
   logic [word_w-1:0]      scalar_i;
   logic [imm_w-1:0]       imm_i;
   alu_op_t                alu_op_i;
   logic [vrf_addr_w-1:0]  vd_addr_i;
   logic                   wb_en_i;
   logic                   wb_load_i;
   logic [word_w-1:0]      load_data_i;
   logic                   masked_i;
   logic [mask_addr_w-1:0] mask_addr_i;
   logic                   mask_wen_i;
   logic [word_w-1:0]      result_o;
   logic                   result_valid_o;

   integer seed = 32'h1f2f_db30;
   int     cycle_count = 0;

   // Reference state
   logic [word_w-1:0]     model_vrf [vrf_depth];
   logic [mask_depth-1:0] model_mask;
   exp_entry_t            exp_pipe [stage_n];

   vector_lane dut_i (.*);

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Something failed");
      $fatal(1, "run stopped");
   endtask

   ////////////////////
   // Reference model
   ////////////////////
   function automatic logic [word_w-1:0] elem_of(input logic [word_w-1:0] w,
                                                 input sew_t sew, input el_idx_t idx);
      case (sew)
         sew_8:   elem_of = (w >> {idx, 3'b000}) & 32'h0000_00ff;
         sew_16:  elem_of = (w >> {idx[0], 4'b0000}) & 32'h0000_ffff;
         sew_32:  elem_of = w;
         default: elem_of = '0;
      endcase
   endfunction

   // New word after writing one element into old
   function automatic logic [word_w-1:0] merge_elem(input logic [word_w-1:0] old,
                                                    input logic [word_w-1:0] elem,
                                                    input sew_t sew, input el_idx_t idx);
      logic [word_w-1:0] keep;
      logic [word_w-1:0] put;
      case (sew)
         sew_8: begin
            keep = 32'h0000_00ff << {idx, 3'b000};
            put  = {24'h0, elem[7:0]} << {idx, 3'b000};
         end
         sew_16: begin
            keep = 32'h0000_ffff << {idx[0], 4'b0000};
            put  = {16'h0, elem[15:0]} << {idx[0], 4'b0000};
         end
         sew_32: begin
            keep = '1;
            put  = elem;
         end
         default: begin
            keep = '0;
            put  = '0;
         end
      endcase
      merge_elem = (old & ~keep) | (put & keep);
   endfunction

   function automatic logic [word_w-1:0] alu_model(input alu_op_t op,
                                                   input logic [word_w-1:0] a,
                                                   input logic [word_w-1:0] b);
      case (op)
         op_add:   alu_model = a + b;
         op_sub:   alu_model = a - b;
         op_and:   alu_model = a & b;
         op_or:    alu_model = a | b;
         op_xor:   alu_model = a ^ b;
         op_mseq:  alu_model = {31'b0, a == b};
         op_msltu: alu_model = {31'b0, a < b};
         default:  alu_model = '0;
      endcase
   endfunction

   function automatic logic [word_w-1:0] next_rand();
      next_rand = $random(seed);
   endfunction

   `include "tb_vector_lane_seq.svh"

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   // Issue at edge n gives a result after n+2 and a write at n+3
   always @(posedge clk_i) begin
      exp_entry_t        e;
      logic [word_w-1:0] op1;
      logic [word_w-1:0] op2;
      if (!rst_i) begin
         model_mask <= '0;
         for (int k = 0; k < stage_n; k++) begin
            exp_pipe[k] <= '0;
         end
      end else begin
         if (exp_pipe[2].valid) begin
            if (exp_pipe[2].wb_en &&
                (!exp_pipe[2].masked || model_mask[exp_pipe[2].mask_addr])) begin
               model_vrf[exp_pipe[2].vd] <= merge_elem(model_vrf[exp_pipe[2].vd],
                  exp_pipe[2].wdata, exp_pipe[2].sew, exp_pipe[2].idx);
            end
            if (exp_pipe[2].mask_wen) begin
               model_mask[exp_pipe[2].mask_addr] <= exp_pipe[2].result[0];
            end
         end
         op1 = elem_of(model_vrf[vs1_addr_i], vsew_i, el_idx_i);
         case (op2_sel_i)
            op2_vector: op2 = elem_of(model_vrf[vs2_addr_i], vsew_i, el_idx_i);
            op2_scalar: op2 = scalar_i;
            op2_imm:    op2 = {{(word_w-imm_w){1'b0}}, imm_i};
            default:    op2 = '0;
         endcase
         e.valid     = issue_valid_i;
         e.result    = alu_model(alu_op_i, op1, op2);
         e.wb_en     = wb_en_i;
         e.vd        = vd_addr_i;
         e.wdata     = wb_load_i ? load_data_i : e.result;
         e.sew       = vsew_i;
         e.idx       = el_idx_i;
         e.masked    = masked_i;
         e.mask_addr = mask_addr_i;
         e.mask_wen  = mask_wen_i;
         if (alu_op_i == op_mseq || alu_op_i == op_msltu) begin
            e.kind = kind_cmp;
         end else if (alu_op_i == op_add && op2_sel_i == op2_imm && imm_i == '0 &&
                      !wb_en_i) begin
            e.kind = kind_read;
         end else begin
            e.kind = kind_alu;
         end
         exp_pipe[0] <= e;
         exp_pipe[1] <= exp_pipe[0];
         exp_pipe[2] <= exp_pipe[1];
      end
   end

   ////////////////////
   // Checks
   ////////////////////
   valid_latency: assert property (@(posedge clk_i) disable iff (!rst_i)
      result_valid_o == exp_pipe[2].valid)
      else fail_run($sformatf("Mismatch at %0t: result_valid_o is %b, expected %b",
         $time, $sampled(result_valid_o), $sampled(exp_pipe[2].valid)));

   alu_result: assert property (@(posedge clk_i) disable iff (!rst_i)
      (exp_pipe[2].valid && exp_pipe[2].kind == kind_alu) |-> result_o == exp_pipe[2].result)
      else fail_run($sformatf("Mismatch at %0t: result_o (ALU) is %h, expected %h",
         $time, $sampled(result_o), $sampled(exp_pipe[2].result)));

   // Readbacks see element, load and masked writes
   readback_result: assert property (@(posedge clk_i) disable iff (!rst_i)
      (exp_pipe[2].valid && exp_pipe[2].kind == kind_read) |-> result_o == exp_pipe[2].result)
      else fail_run($sformatf("Mismatch at %0t: result_o (readback) is %h, expected %h",
         $time, $sampled(result_o), $sampled(exp_pipe[2].result)));

   compare_result: assert property (@(posedge clk_i) disable iff (!rst_i)
      (exp_pipe[2].valid && exp_pipe[2].kind == kind_cmp) |-> result_o == exp_pipe[2].result)
      else fail_run($sformatf("Mismatch at %0t: result_o (compare) is %h, expected %h",
         $time, $sampled(result_o), $sampled(exp_pipe[2].result)));

   always @(posedge clk_i) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         fail_run($sformatf("Timeout: the test sequence did not end within %0d cycles",
                            cycle_limit));
      end
   end

   initial begin
      clear_inputs();
      rst_i <= 1'b0;
      repeat (reset_cycles) @(posedge clk_i);
      rst_i <= 1'b1;
      run_tests();
      // The last result is checked on the edge before this one
      idle_cycles(1);
      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

//--- vector_lane.f
+incdir+testbench
source/vlane_pkg.sv
source/vlane_vrf.sv
source/vlane_mask_file.sv
source/vlane_issue_pipe.sv
source/vlane_operand_extract.sv
source/vlane_alu.sv
source/vlane_writeback.sv
source/vector_lane.sv
testbench/tb_vector_lane.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the vector lane testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir

verilator --binary --timing --assert -f vector_lane.f \
   --top-module tb_vector_lane -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/Vtb_vector_lane > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   echo "FAIL"
   exit 1
fi

if grep -qx "Everything OK" "$log"; then
   echo "PASS"
   exit 0
fi
echo "FAIL"
exit 1
